// ==== Bender.yml ====
package:
  name: bram_tile

sources:
  # package first, then leaf modules, then the top level
  - hdl/bram_pkg.sv
  - hdl/bram_config_regs.sv
  - hdl/bram_write_lane.sv
  - hdl/bram_read_lane.sv
  - hdl/sram_1rw1r_256x32.sv
  - hdl/bram_tile.sv

  # testbench, top module bram_tile_tb
  - target: test
    files:
      - dv/bram_tile_tb.sv

// ==== dv/bram_tile_tb.sv ====
module bram_tile_tb;

  import bram_pkg::*;

  logic              clk;
  logic              arst_n;
  logic              cfg_strobe;
  logic [cfg_w-1:0]  cfg_data;
  logic [addr_w-1:0] wr_addr;
  logic [data_w-1:0] wr_data;
  logic [addr_w-1:0] rd_addr;
  logic [data_w-1:0] rd_data;

  // reference model state
  logic [data_w-1:0] ref_mem [depth];
  width_mode_t       cur_wr_mode;
  width_mode_t       cur_rd_mode;
  logic              cur_force_we;
  logic              cur_out_reg;
  logic              write_due;

  // expected read pipeline, one entry per latency stage
  logic              chk_rd;             // this cycle's read gets checked
  logic              s1_valid;
  logic [data_w-1:0] s1_exp;
  logic              s2_valid;
  logic [data_w-1:0] s2_exp;

  logic [addr_w-1:0] addr_list [4];

  int seed         = 6;
  int errors       = 0;
  int timeouts     = 0;
  int reads_issued = 0;
  int checks_done  = 0;

  bram_tile bram_tile_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg_strobe (cfg_strobe),
    .cfg_data   (cfg_data),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // new word after a write, per lane placement rules
  function automatic logic [data_w-1:0] apply_write(input logic [data_w-1:0] old_word,
                                                    input logic [data_w-1:0] data,
                                                    input width_mode_t mode,
                                                    input logic [sel_w-1:0] sel);
    logic [data_w-1:0] w;
    w = old_word;
    case (mode)
      MODE_W32: w = data;
      MODE_W16: begin
        if (sel == 2'd0) w[15:0] = data[15:0];
        else w[31:16] = data[15:0];     // any nonzero select
      end
      MODE_W8:  w[8*sel +: 8] = data[7:0];
      default:  w = old_word;           // reserved, no write
    endcase
    return w;
  endfunction

  // what the read port shows for a stored word
  function automatic logic [data_w-1:0] read_view(input logic [data_w-1:0] word,
                                                  input width_mode_t mode,
                                                  input logic [sel_w-1:0] sel);
    logic [data_w-1:0] r;
    r = word;
    if (mode == MODE_W16) begin
      r[15:0] = sel[0] ? word[31:16] : word[15:0];
    end else if (mode == MODE_W8) begin
      r[7:0] = word[8*sel +: 8];
    end
    return r;
  endfunction

  // payload with the in-band control fields placed on top
  function automatic logic [data_w-1:0] make_word(input logic [data_w-1:0] payload,
                                                  input logic we,
                                                  input logic [sel_w-1:0] wsel,
                                                  input logic [sel_w-1:0] rsel);
    logic [data_w-1:0] w;
    w = payload;
    w[def_we_bit] = we;
    w[def_wr_sel_lsb +: sel_w] = wsel;
    w[def_rd_sel_lsb +: sel_w] = rsel;
    return w;
  endfunction

  assign write_due = (cur_force_we || wr_data[def_we_bit]) && (cur_wr_mode != MODE_RSVD);

  // config shadow and expected-value pipeline
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cur_wr_mode  <= MODE_W32;
      cur_rd_mode  <= MODE_W32;
      cur_force_we <= 1'b0;
      cur_out_reg  <= 1'b0;
      s1_valid     <= 1'b0;
      s1_exp       <= '0;
      s2_valid     <= 1'b0;
      s2_exp       <= '0;
    end else begin
      if (cfg_strobe) begin
        cur_wr_mode  <= width_mode_t'(cfg_data[cfg_wr_mode_lsb +: mode_w]);
        cur_rd_mode  <= width_mode_t'(cfg_data[cfg_rd_mode_lsb +: mode_w]);
        cur_force_we <= cfg_data[cfg_force_we_bit];
        cur_out_reg  <= cfg_data[cfg_out_reg_bit];
      end
      s1_valid <= chk_rd;
      // old word on a same-cycle write
      s1_exp   <= read_view(ref_mem[rd_addr], cur_rd_mode, wr_data[def_rd_sel_lsb +: sel_w]);
      s2_valid <= s1_valid & cur_out_reg;
      s2_exp   <= s1_exp;
    end
  end

  always @(posedge clk) begin
    if (arst_n && write_due) begin
      ref_mem[wr_addr] <= apply_write(ref_mem[wr_addr], wr_data, cur_wr_mode,
                                      wr_data[def_wr_sel_lsb +: sel_w]);
    end
  end

  always @(posedge clk) begin
    if (arst_n && ((s1_valid && !cur_out_reg) || (s2_valid && cur_out_reg))) begin
      checks_done++;
    end
  end

  // one cycle latency, output register bypassed
  a_rd_bypass: assert property (
    @(posedge clk) disable iff (!arst_n)
    (s1_valid && !cur_out_reg) |-> (rd_data === s1_exp)
  ) else begin
    $display("** Error at %0t: rd_data expected %08h, actual %08h",
             $time, $sampled(s1_exp), $sampled(rd_data));
    errors++;
  end

  // two cycle latency through the output register
  a_rd_registered: assert property (
    @(posedge clk) disable iff (!arst_n)
    (s2_valid && cur_out_reg) |-> (rd_data === s2_exp)
  ) else begin
    $display("** Error at %0t: rd_data expected %08h, actual %08h",
             $time, $sampled(s2_exp), $sampled(rd_data));
    errors++;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;  // drive just after the edge
  endtask

  task automatic load_cfg(input width_mode_t wm, input width_mode_t rm,
                          input logic fw, input logic oreg);
    cfg_data = '0;
    cfg_data[cfg_wr_mode_lsb +: mode_w] = wm;
    cfg_data[cfg_rd_mode_lsb +: mode_w] = rm;
    cfg_data[cfg_force_we_bit] = fw;
    cfg_data[cfg_out_reg_bit]  = oreg;
    cfg_strobe = 1'b1;
    chk_rd     = 1'b0;
    wr_data    = '0;
    next_cycle();
    cfg_strobe = 1'b0;
  endtask

  task automatic write_word(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    wr_addr = a;
    wr_data = d;
    chk_rd  = 1'b0;
    next_cycle();
  endtask

  task automatic read_word(input logic [addr_w-1:0] a, input logic [sel_w-1:0] rsel);
    logic [data_w-1:0] filler;
    filler  = $random(seed);
    rd_addr = a;
    wr_data = make_word(filler, 1'b0, 2'd0, rsel);  // no dynamic write
    chk_rd  = 1'b1;
    reads_issued++;
    next_cycle();
  endtask

  // wait until every read in flight has been compared
  task automatic drain_reads();
    int n;
    chk_rd  = 1'b0;
    wr_data = '0;
    n = 0;
    while ((s1_valid || s2_valid) && n < 8) begin
      next_cycle();
      n++;
    end
    if (s1_valid || s2_valid) begin
      $display("timeout: read pipeline still busy after %0d cycles", n);
      timeouts++;
    end
  endtask

  initial begin
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    arst_n     = 1'b0;
    cfg_strobe = 1'b0;
    cfg_data   = '0;
    wr_addr    = '0;
    wr_data    = '0;
    rd_addr    = '0;
    chk_rd     = 1'b0;
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;

    // full words with the reset config, whole array gets known contents
    for (int i = 0; i < depth; i++) begin
      d = $random(seed);
      d[def_we_bit] = 1'b1;
      write_word(addr_w'(i), d);
    end
    for (int i = 0; i < depth; i++) begin
      read_word(addr_w'(i), 2'd0);
    end
    for (int i = 0; i < 16; i++) begin
      a = addr_w'($random(seed));
      d = $random(seed);
      write_word(a, make_word(d, 1'b1, 2'd0, 2'd0));
      read_word(a, 2'd0);
    end
    drain_reads();

    // byte writes, full word reads
    load_cfg(MODE_W8, MODE_W32, 1'b0, 1'b0);
    for (int s = 0; s < 4; s++) begin
      a = addr_w'($random(seed));
      d = $random(seed);
      write_word(a, make_word(d, 1'b1, sel_w'(s), 2'd0));
      read_word(a, 2'd0);
    end
    drain_reads();

    // half word writes, then narrow reads of both kinds
    load_cfg(MODE_W16, MODE_W16, 1'b0, 1'b0);
    for (int s = 0; s < 4; s++) begin
      addr_list[s] = addr_w'($random(seed));
      d = $random(seed);
      write_word(addr_list[s], make_word(d, 1'b1, sel_w'(s), 2'd0));
    end
    for (int i = 0; i < 4; i++) begin
      for (int s = 0; s < 4; s++) read_word(addr_list[i], sel_w'(s));
    end
    drain_reads();
    load_cfg(MODE_W16, MODE_W8, 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      for (int s = 0; s < 4; s++) read_word(addr_list[i], sel_w'(s));
    end
    drain_reads();

    // dynamic enable clear, without and with force
    load_cfg(MODE_W32, MODE_W32, 1'b0, 1'b0);
    a = addr_w'($random(seed));
    d = $random(seed);
    write_word(a, make_word(d, 1'b0, 2'd0, 2'd0));
    read_word(a, 2'd0);  // word must be unchanged
    drain_reads();
    load_cfg(MODE_W32, MODE_W32, 1'b1, 1'b0);
    write_word(a, make_word(d, 1'b0, 2'd0, 2'd0));
    read_word(a, 2'd0);
    drain_reads();
    load_cfg(MODE_W32, MODE_W32, 1'b0, 1'b0);
    read_word(a, 2'd0);
    drain_reads();

    // output register on, a read every cycle
    load_cfg(MODE_W32, MODE_W32, 1'b0, 1'b1);
    for (int i = 0; i < 32; i++) begin
      read_word(addr_w'($random(seed)), 2'd0);
    end
    drain_reads();
    load_cfg(MODE_W32, MODE_W8, 1'b0, 1'b1);
    for (int i = 0; i < 16; i++) begin
      a = addr_w'($random(seed));
      read_word(a, sel_w'(i));
    end
    drain_reads();

    if (checks_done != reads_issued) begin
      $display("read count mismatch: %0d reads issued but %0d compared",
               reads_issued, checks_done);
      errors++;
    end
    $display("errors: %0d, timeouts: %0d, reads checked: %0d", errors, timeouts, checks_done);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hdl/bram_config_regs.sv ====
module bram_config_regs (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        cfg_strobe,
  input  logic [bram_pkg::cfg_w-1:0]  cfg_data,
  output bram_pkg::width_mode_t       wr_mode,
  output bram_pkg::width_mode_t       rd_mode,
  output logic                        force_we,
  output logic                        out_reg_en
);

  import bram_pkg::*;

  logic [cfg_w-1:0] frame_q;

  // frame register, loaded in parallel on the strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_q                              <= '0;
      frame_q[cfg_wr_mode_lsb +: mode_w]   <= MODE_W32;
      frame_q[cfg_rd_mode_lsb +: mode_w]   <= MODE_W32;
    end else if (cfg_strobe) begin
      frame_q <= cfg_data;
    end
  end

  // field decode
  assign wr_mode    = width_mode_t'(frame_q[cfg_wr_mode_lsb +: mode_w]);
  assign rd_mode    = width_mode_t'(frame_q[cfg_rd_mode_lsb +: mode_w]);
  assign force_we   = frame_q[cfg_force_we_bit];
  assign out_reg_en = frame_q[cfg_out_reg_bit];  // adds one cycle of read latency

  // a reserved write mode silently disables every write, which
  // usually means the fabric bitstream was built for another tile
  a_no_rsvd_wr_mode: assert property (
    @(posedge clk) disable iff (!arst_n)
    cfg_strobe |=> (wr_mode != MODE_RSVD)
  ) else $error("bram_config_regs: reserved write mode loaded");

endmodule

// ==== hdl/bram_pkg.sv ====
package bram_pkg;

  // word geometry
  localparam int data_w = 32;
  localparam int addr_w = 8;
  localparam int depth  = 1 << addr_w;
  localparam int mask_w = 4;                // byte lanes per word
  localparam int byte_w = data_w / mask_w;
  localparam int half_w = data_w / 2;
  localparam int sel_w  = 2;                // lane select fields carried in wr_data

  // port width modes, shared by the write and read side
  typedef enum logic [1:0] {
    MODE_W32  = 2'd0,
    MODE_W16  = 2'd1,
    MODE_W8   = 2'd2,
    MODE_RSVD = 2'd3
  } width_mode_t;

  localparam int mode_w = $bits(width_mode_t);

  // configuration frame layout
  localparam int cfg_w            = 6;
  localparam int cfg_wr_mode_lsb  = 0;      // bits 1:0
  localparam int cfg_rd_mode_lsb  = 2;      // bits 3:2
  localparam int cfg_force_we_bit = 4;
  localparam int cfg_out_reg_bit  = 5;

  // where the fabric normally routes the in-band control fields
  localparam int def_wr_sel_lsb = 16;       // upper write lane select, 2 bits
  localparam int def_we_bit     = 20;       // dynamic write enable
  localparam int def_rd_sel_lsb = 24;       // upper read lane select, 2 bits

endpackage

// ==== hdl/bram_read_lane.sv ====
module bram_read_lane #(
  parameter int rd_sel_lsb = bram_pkg::def_rd_sel_lsb
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  bram_pkg::width_mode_t        rd_mode,
  input  logic                         out_reg_en,
  input  logic [bram_pkg::data_w-1:0]  wr_data,
  input  logic [bram_pkg::data_w-1:0]  mem_dout,
  output logic [bram_pkg::data_w-1:0]  rd_data
);

  import bram_pkg::*;

  logic [sel_w-1:0]  rd_sel_q;
  logic [data_w-1:0] lane_data;
  logic [data_w-1:0] out_q;

  // the macro samples rd_addr at the same edge, so the select
  // is registered here to line up with mem_dout
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_sel_q <= '0;
    end else begin
      rd_sel_q <= wr_data[rd_sel_lsb +: sel_w];
    end
  end

  // narrow modes only replace the low bits, upper bits stay raw
  always_comb begin
    lane_data = mem_dout;
    unique case (rd_mode)
      MODE_W16: begin
        if (rd_sel_q[0]) begin
          lane_data[half_w-1:0] = mem_dout[half_w +: half_w];
        end else begin
          lane_data[half_w-1:0] = mem_dout[half_w-1:0];
        end
      end
      MODE_W8: begin
        lane_data[byte_w-1:0] = mem_dout[rd_sel_q*byte_w +: byte_w];
      end
      MODE_W32, MODE_RSVD: begin
        lane_data = mem_dout;  // raw word
      end
    endcase
  end

  // optional output stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_q <= '0;
    end else begin
      out_q <= lane_data;
    end
  end

  assign rd_data = out_reg_en ? out_q : lane_data;  // bypass when the register is off

endmodule

// ==== hdl/bram_tile.sv ====
module bram_tile #(
  parameter int wr_sel_lsb = bram_pkg::def_wr_sel_lsb,
  parameter int we_bit     = bram_pkg::def_we_bit,
  parameter int rd_sel_lsb = bram_pkg::def_rd_sel_lsb
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         cfg_strobe,
  input  logic [bram_pkg::cfg_w-1:0]   cfg_data,
  input  logic [bram_pkg::addr_w-1:0]  wr_addr,
  input  logic [bram_pkg::data_w-1:0]  wr_data,
  input  logic [bram_pkg::addr_w-1:0]  rd_addr,
  output logic [bram_pkg::data_w-1:0]  rd_data
);

  import bram_pkg::*;

  width_mode_t       wr_mode;
  width_mode_t       rd_mode;
  logic              force_we;
  logic              out_reg_en;
  logic              mem_we_n;
  logic [mask_w-1:0] mem_wmask;
  logic [data_w-1:0] mem_din;
  logic [data_w-1:0] mem_dout;

  bram_config_regs bram_config_regs_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg_strobe (cfg_strobe),
    .cfg_data   (cfg_data),
    .wr_mode    (wr_mode),
    .rd_mode    (rd_mode),
    .force_we   (force_we),
    .out_reg_en (out_reg_en)
  );

  bram_write_lane #(
    .wr_sel_lsb (wr_sel_lsb),
    .we_bit     (we_bit)
  ) bram_write_lane_inst (
    .wr_mode   (wr_mode),
    .force_we  (force_we),
    .wr_data   (wr_data),
    .mem_we_n  (mem_we_n),
    .mem_wmask (mem_wmask),
    .mem_din   (mem_din)
  );

  // port 0 selected only while writing, port 1 always reading
  sram_1rw1r_256x32 sram_inst (
    .clk0   (clk),
    .csb0   (mem_we_n),
    .web0   (mem_we_n),
    .wmask0 (mem_wmask),
    .addr0  (wr_addr),
    .din0   (mem_din),
    .clk1   (clk),
    .csb1   (1'b0),
    .addr1  (rd_addr),
    .dout1  (mem_dout)
  );

  bram_read_lane #(
    .rd_sel_lsb (rd_sel_lsb)
  ) bram_read_lane_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .rd_mode    (rd_mode),
    .out_reg_en (out_reg_en),
    .wr_data    (wr_data),   // read select rides in the write word
    .mem_dout   (mem_dout),
    .rd_data    (rd_data)
  );

endmodule

// ==== hdl/bram_write_lane.sv ====
module bram_write_lane #(
  parameter int wr_sel_lsb = bram_pkg::def_wr_sel_lsb,
  parameter int we_bit     = bram_pkg::def_we_bit
) (
  input  bram_pkg::width_mode_t        wr_mode,
  input  logic                         force_we,
  input  logic [bram_pkg::data_w-1:0]  wr_data,
  output logic                         mem_we_n,
  output logic [bram_pkg::mask_w-1:0]  mem_wmask,
  output logic [bram_pkg::data_w-1:0]  mem_din
);

  import bram_pkg::*;

  logic [sel_w-1:0] wr_sel;
  logic             we;

  assign wr_sel = wr_data[wr_sel_lsb +: sel_w];
  assign we     = force_we | wr_data[we_bit];

  // byte mask and lane replication
  always_comb begin
    mem_wmask = '0;
    mem_din   = wr_data;
    unique case (wr_mode)
      MODE_W32: begin
        mem_wmask = '1;
      end
      MODE_W16: begin
        // any nonzero select picks the upper half
        mem_wmask = (wr_sel == '0) ? mask_w'(4'b0011) : mask_w'(4'b1100);
        mem_din   = {2{wr_data[half_w-1:0]}};
      end
      MODE_W8: begin
        mem_wmask = mask_w'(1) << wr_sel;
        mem_din   = {mask_w{wr_data[byte_w-1:0]}};  // every lane carries the byte
      end
      MODE_RSVD: begin
        mem_wmask = '0;  // nothing gets written
      end
    endcase
  end

  // no strobe at all when the mask is empty
  assign mem_we_n = ~(we & (|mem_wmask));

endmodule

// ==== hdl/sram_1rw1r_256x32.sv ====
module sram_1rw1r_256x32 (
  // port 0, used as write port only
  input  logic                         clk0,
  input  logic                         csb0,    // active low
  input  logic                         web0,    // active low
  input  logic [bram_pkg::mask_w-1:0]  wmask0,
  input  logic [bram_pkg::addr_w-1:0]  addr0,
  input  logic [bram_pkg::data_w-1:0]  din0,
  // port 1, read only
  input  logic                         clk1,
  input  logic                         csb1,    // active low
  input  logic [bram_pkg::addr_w-1:0]  addr1,
  output logic [bram_pkg::data_w-1:0]  dout1
);

  import bram_pkg::*;

  logic [data_w-1:0] mem [depth];

  // byte masked write
  always_ff @(posedge clk0) begin
    if (!csb0 && !web0) begin
      for (int i = 0; i < mask_w; i++) begin
        if (wmask0[i]) begin
          mem[addr0][i*byte_w +: byte_w] <= din0[i*byte_w +: byte_w];
        end
      end
    end
  end

  // registered read
  // same-address write in the same cycle returns the old word
  always_ff @(posedge clk1) begin
    if (!csb1) begin
      dout1 <= mem[addr1];
    end
  end

  // a deselected port must not see a write strobe, the tile ties both
  // controls to one net so this catches broken wiring above
  a_no_write_deselected: assert property (
    @(posedge clk0) csb0 |-> web0
  ) else $error("sram_1rw1r_256x32: web0 low while csb0 high");

endmodule

// ==== list.f ====
hdl/bram_pkg.sv
hdl/bram_config_regs.sv
hdl/bram_write_lane.sv
hdl/bram_read_lane.sv
hdl/sram_1rw1r_256x32.sv
hdl/bram_tile.sv
dv/bram_tile_tb.sv
